// ==== ic_cfg_pkg.sv ====
package ic_cfg_pkg;

  // core side
  localparam int unsigned N_CORE = 4;
  localparam int unsigned DW     = 32;
  localparam int unsigned BEW    = 4;
  localparam int unsigned AW     = 16;     // byte address

  // byte lanes
  localparam int unsigned BYTE_W     = DW / BEW;
  localparam int unsigned BYTE_OFF_W = $clog2(BEW);   // word offset bits 1..0

  // bank side
  localparam int unsigned N_BANK     = 4;
  localparam int unsigned BANK_AW    = 6;
  localparam int unsigned BANK_WORDS = 2 ** BANK_AW;  // 64 words per bank

  // address fields, word interleaved
  // [1:0] byte offset, [3:2] bank index, [9:4] word in bank
  localparam int unsigned BANK_SEL_W    = 2;
  localparam int unsigned BANK_ADDR_LSB = 4;

  // high address bit turns any access into a test-and-set
  localparam int unsigned TS_BIT = 12;

  // request id carried through the bank, one id per core
  localparam int unsigned CORE_IDX_W = 2;

endpackage

// ==== ic_types_pkg.sv ====
package ic_types_pkg;

  // arbitration policy, selectable at run time
  typedef enum logic {
    ARB_ROUND_ROBIN = 1'b0,  // start one past last winner
    ARB_FIXED_PRIO  = 1'b1   // lowest core index wins
  } arb_policy_e;

  // operation presented to a bank
  // test-and-set returns the old word and stores all ones
  typedef enum logic [1:0] {
    OP_READ     = 2'd0,
    OP_WRITE    = 2'd1,
    OP_TEST_SET = 2'd2
  } bank_op_e;

endpackage

// ==== tcdm_bank_intf.sv ====
interface tcdm_bank_intf;

  // request side, set up by the crossbar
  logic                                req;    // level, one access per cycle
  ic_types_pkg::bank_op_e              op;
  logic [ic_cfg_pkg::BANK_AW-1:0]      addr;   // word address in bank
  logic [ic_cfg_pkg::DW-1:0]           wdata;
  logic [ic_cfg_pkg::BEW-1:0]          be;
  logic [ic_cfg_pkg::CORE_IDX_W-1:0]   id;     // issuing core

  // response side, registered in the bank
  logic                                r_valid;
  logic [ic_cfg_pkg::DW-1:0]           r_rdata;
  logic [ic_cfg_pkg::CORE_IDX_W-1:0]   r_id;

  modport initiator (
    output req, op, addr, wdata, be, id,
    input  r_valid, r_rdata, r_id
  );

  modport target (
    input  req, op, addr, wdata, be, id,
    output r_valid, r_rdata, r_id
  );

  // response observer, used by the response router
  modport monitor (
    input r_valid, r_rdata, r_id
  );

endinterface

// ==== ic_req_xbar.sv ====
module ic_req_xbar (
  // core requests
  input  logic [ic_cfg_pkg::N_CORE-1:0]                         core_req_i,
  input  logic [ic_cfg_pkg::N_CORE-1:0]                         core_we_i,
  input  logic [ic_cfg_pkg::N_CORE-1:0][ic_cfg_pkg::AW-1:0]     core_add_i,
  input  logic [ic_cfg_pkg::N_CORE-1:0][ic_cfg_pkg::DW-1:0]     core_wdata_i,
  input  logic [ic_cfg_pkg::N_CORE-1:0][ic_cfg_pkg::BEW-1:0]    core_be_i,
  // to and from the arbiter
  output logic [ic_cfg_pkg::N_BANK-1:0][ic_cfg_pkg::N_CORE-1:0] bank_req_o,
  input  logic [ic_cfg_pkg::N_BANK-1:0][ic_cfg_pkg::CORE_IDX_W-1:0] winner_i,
  input  logic [ic_cfg_pkg::N_BANK-1:0]                         winner_valid_i,
  // bank request buses
  tcdm_bank_intf.initiator                                      banks [ic_cfg_pkg::N_BANK]
);

  logic [ic_cfg_pkg::N_CORE-1:0][ic_cfg_pkg::BANK_SEL_W-1:0] bank_sel;
  logic [ic_cfg_pkg::N_CORE-1:0][ic_cfg_pkg::BANK_AW-1:0]    word_addr;
  ic_types_pkg::bank_op_e                                    core_op [ic_cfg_pkg::N_CORE];

  // address decode and opcode per core
  always_comb begin : decode
    for (int c = 0; c < ic_cfg_pkg::N_CORE; c++) begin
      bank_sel[c]  = core_add_i[c][ic_cfg_pkg::BYTE_OFF_W +: ic_cfg_pkg::BANK_SEL_W];
      word_addr[c] = core_add_i[c][ic_cfg_pkg::BANK_ADDR_LSB +: ic_cfg_pkg::BANK_AW];
      if (core_add_i[c][ic_cfg_pkg::TS_BIT]) begin
        core_op[c] = ic_types_pkg::OP_TEST_SET;   // ts bit overrides we
      end else if (core_we_i[c]) begin
        core_op[c] = ic_types_pkg::OP_WRITE;
      end else begin
        core_op[c] = ic_types_pkg::OP_READ;
      end
    end
  end

  // request matrix seen by the arbiter
  always_comb begin : req_matrix
    for (int b = 0; b < ic_cfg_pkg::N_BANK; b++) begin
      for (int c = 0; c < ic_cfg_pkg::N_CORE; c++) begin
        bank_req_o[b][c] = core_req_i[c] && (bank_sel[c] == b[ic_cfg_pkg::BANK_SEL_W-1:0]);
      end
    end
  end

  // steer the winner of each bank onto its bus
  for (genvar b = 0; b < ic_cfg_pkg::N_BANK; b++) begin : gen_bank_mux
    assign banks[b].req   = winner_valid_i[b];
    assign banks[b].op    = core_op[winner_i[b]];
    assign banks[b].addr  = word_addr[winner_i[b]];
    assign banks[b].wdata = core_wdata_i[winner_i[b]];
    assign banks[b].be    = core_be_i[winner_i[b]];
    assign banks[b].id    = winner_i[b];   // comes back as r_id
  end

endmodule

// ==== ic_bank_arbiter.sv ====
module ic_bank_arbiter (
  input  logic                                                      clk_i,
  input  logic                                                      rst_ni,
  input  ic_types_pkg::arb_policy_e                                 policy_i,
  input  logic [ic_cfg_pkg::N_BANK-1:0][ic_cfg_pkg::N_CORE-1:0]     bank_req_i,
  output logic [ic_cfg_pkg::N_BANK-1:0][ic_cfg_pkg::CORE_IDX_W-1:0] winner_o,
  output logic [ic_cfg_pkg::N_BANK-1:0]                             winner_valid_o,
  output logic [ic_cfg_pkg::N_CORE-1:0]                             core_gnt_o
);

  // per bank, the core index the round-robin search starts from
  logic [ic_cfg_pkg::N_BANK-1:0][ic_cfg_pkg::CORE_IDX_W-1:0] rr_ptr_q;
  logic [ic_cfg_pkg::N_BANK-1:0][ic_cfg_pkg::CORE_IDX_W-1:0] search_start;

  always_comb begin : start_sel
    for (int b = 0; b < ic_cfg_pkg::N_BANK; b++) begin
      if (policy_i == ic_types_pkg::ARB_FIXED_PRIO) begin
        search_start[b] = '0;           // core 0 always first
      end else begin
        search_start[b] = rr_ptr_q[b];
      end
    end
  end

  // first requesting core at or after the start index, wrapping
  always_comb begin : pick_winner
    logic [ic_cfg_pkg::CORE_IDX_W-1:0] idx;
    logic                              found;

    winner_o       = '0;
    winner_valid_o = '0;
    for (int b = 0; b < ic_cfg_pkg::N_BANK; b++) begin
      found = 1'b0;
      for (int k = 0; k < ic_cfg_pkg::N_CORE; k++) begin
        idx = search_start[b] + k[ic_cfg_pkg::CORE_IDX_W-1:0];  // wraps mod N_CORE
        if (!found && bank_req_i[b][idx]) begin
          winner_o[b] = idx;
          found       = 1'b1;
        end
      end
      winner_valid_o[b] = found;
    end
  end

  // a core asks one bank at a time, so at most one bank grants it
  always_comb begin : grant_map
    core_gnt_o = '0;
    for (int b = 0; b < ic_cfg_pkg::N_BANK; b++) begin
      if (winner_valid_o[b]) begin
        core_gnt_o[winner_o[b]] = 1'b1;
      end
    end
  end

  // next search begins one past this cycle's winner
  always_ff @(posedge clk_i or negedge rst_ni) begin : rr_update
    if (!rst_ni) begin
      rr_ptr_q <= '0;
    end else begin
      for (int b = 0; b < ic_cfg_pkg::N_BANK; b++) begin
        if (winner_valid_o[b]) begin
          rr_ptr_q[b] <= winner_o[b] + 1'b1;
        end
      end
    end
  end

endmodule

// ==== tcdm_bank.sv ====
module tcdm_bank (
  input  logic          clk_i,
  input  logic          rst_ni,
  tcdm_bank_intf.target bus
);

  logic [ic_cfg_pkg::DW-1:0] mem_q [ic_cfg_pkg::BANK_WORDS];
  logic [ic_cfg_pkg::DW-1:0] merged_word;

  // byte-lane merge of old word and write data
  always_comb begin : byte_merge
    merged_word = mem_q[bus.addr];
    for (int i = 0; i < ic_cfg_pkg::BEW; i++) begin
      if (bus.be[i]) begin
        merged_word[i*ic_cfg_pkg::BYTE_W +: ic_cfg_pkg::BYTE_W] =
          bus.wdata[i*ic_cfg_pkg::BYTE_W +: ic_cfg_pkg::BYTE_W];
      end
    end
  end

  // single-cycle array access
  always_ff @(posedge clk_i) begin : mem_access
    if (bus.req) begin
      unique case (bus.op)
        ic_types_pkg::OP_WRITE: begin
          mem_q[bus.addr] <= merged_word;   // r_rdata left as is
        end
        ic_types_pkg::OP_TEST_SET: begin
          bus.r_rdata     <= mem_q[bus.addr];  // old word out
          mem_q[bus.addr] <= '1;               // lock taken
        end
        default: begin
          bus.r_rdata <= mem_q[bus.addr];
        end
      endcase
      bus.r_id <= bus.id;
    end
  end

  // one response per access, read, write or test-and-set
  always_ff @(posedge clk_i or negedge rst_ni) begin : resp_valid
    if (!rst_ni) begin
      bus.r_valid <= 1'b0;
    end else begin
      bus.r_valid <= bus.req;
    end
  end

endmodule

// ==== ic_resp_router.sv ====
module ic_resp_router (
  tcdm_bank_intf.monitor                                    banks [ic_cfg_pkg::N_BANK],
  output logic [ic_cfg_pkg::N_CORE-1:0]                     core_r_valid_o,
  output logic [ic_cfg_pkg::N_CORE-1:0][ic_cfg_pkg::DW-1:0] core_r_rdata_o
);

  logic [ic_cfg_pkg::N_BANK-1:0]                         bank_r_valid;
  logic [ic_cfg_pkg::N_BANK-1:0][ic_cfg_pkg::DW-1:0]     bank_r_rdata;
  logic [ic_cfg_pkg::N_BANK-1:0][ic_cfg_pkg::CORE_IDX_W-1:0] bank_r_id;

  // flatten the bank responses so they can be searched in a loop
  for (genvar b = 0; b < ic_cfg_pkg::N_BANK; b++) begin : gen_unroll
    assign bank_r_valid[b] = banks[b].r_valid;
    assign bank_r_rdata[b] = banks[b].r_rdata;
    assign bank_r_id[b]    = banks[b].r_id;
  end

  // at most one bank answers a given core in a cycle
  always_comb begin : route
    core_r_valid_o = '0;
    core_r_rdata_o = '0;
    for (int c = 0; c < ic_cfg_pkg::N_CORE; c++) begin
      for (int b = 0; b < ic_cfg_pkg::N_BANK; b++) begin
        if (bank_r_valid[b] && (bank_r_id[b] == c[ic_cfg_pkg::CORE_IDX_W-1:0])) begin
          core_r_valid_o[c] = 1'b1;
          core_r_rdata_o[c] = bank_r_rdata[b];
        end
      end
    end
  end

endmodule

// ==== log_interconnect_top.sv ====
module log_interconnect_top (
  input  logic                                              clk_i,
  input  logic                                              rst_ni,
  input  ic_types_pkg::arb_policy_e                         arb_policy_i,
  // core request ports
  input  logic [ic_cfg_pkg::N_CORE-1:0]                     core_req_i,
  input  logic [ic_cfg_pkg::N_CORE-1:0]                     core_we_i,
  input  logic [ic_cfg_pkg::N_CORE-1:0][ic_cfg_pkg::AW-1:0]  core_add_i,
  input  logic [ic_cfg_pkg::N_CORE-1:0][ic_cfg_pkg::DW-1:0]  core_wdata_i,
  input  logic [ic_cfg_pkg::N_CORE-1:0][ic_cfg_pkg::BEW-1:0] core_be_i,
  // core response ports
  output logic [ic_cfg_pkg::N_CORE-1:0]                     core_gnt_o,
  output logic [ic_cfg_pkg::N_CORE-1:0]                     core_r_valid_o,
  output logic [ic_cfg_pkg::N_CORE-1:0][ic_cfg_pkg::DW-1:0]  core_r_rdata_o
);

  // crossbar <-> arbiter
  logic [ic_cfg_pkg::N_BANK-1:0][ic_cfg_pkg::N_CORE-1:0]     bank_req;
  logic [ic_cfg_pkg::N_BANK-1:0][ic_cfg_pkg::CORE_IDX_W-1:0] winner;
  logic [ic_cfg_pkg::N_BANK-1:0]                             winner_valid;

  // one bus per bank
  tcdm_bank_intf bank_if [ic_cfg_pkg::N_BANK] ();

  ic_req_xbar i_req_xbar (
    .core_req_i     ( core_req_i   ),
    .core_we_i      ( core_we_i    ),
    .core_add_i     ( core_add_i   ),
    .core_wdata_i   ( core_wdata_i ),
    .core_be_i      ( core_be_i    ),
    .bank_req_o     ( bank_req     ),
    .winner_i       ( winner       ),
    .winner_valid_i ( winner_valid ),
    .banks          ( bank_if      )
  );

  // grants are combinational, same cycle as req
  ic_bank_arbiter i_bank_arbiter (
    .clk_i          ( clk_i        ),
    .rst_ni         ( rst_ni       ),
    .policy_i       ( arb_policy_i ),
    .bank_req_i     ( bank_req     ),
    .winner_o       ( winner       ),
    .winner_valid_o ( winner_valid ),
    .core_gnt_o     ( core_gnt_o   )
  );

  for (genvar b = 0; b < ic_cfg_pkg::N_BANK; b++) begin : gen_banks
    tcdm_bank i_bank (
      .clk_i  ( clk_i      ),
      .rst_ni ( rst_ni     ),
      .bus    ( bank_if[b] )
    );
  end

  // responses land one cycle after the accepting edge
  ic_resp_router i_resp_router (
    .banks          ( bank_if        ),
    .core_r_valid_o ( core_r_valid_o ),
    .core_r_rdata_o ( core_r_rdata_o )
  );

endmodule

// ==== tb_clk_gen.sv ====
module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  localparam int unsigned HALF_PERIOD = 5;  // period 10
  localparam int unsigned RST_CYCLES  = 4;

  initial begin : clock
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;
  end

  // reset released on the 4th rising edge
  initial begin : reset
    rst_no = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

// ==== tb_log_interconnect.sv ====
module tb_log_interconnect;

  // column layout of one pattern row
  localparam int COL_TEST   = 0;
  localparam int COL_REQ    = 1;
  localparam int COL_WE     = 2;
  localparam int COL_POL    = 3;
  localparam int COL_BE     = 4;   // core3..core0 nibbles
  localparam int COL_ADD    = 5;
  localparam int COL_WDATA  = 9;
  localparam int COL_GNT    = 13;
  localparam int COL_MASK   = 14;  // which cores have rdata to compare
  localparam int COL_RDATA  = 15;
  localparam int N_COL      = 19;
  localparam int MAX_ROWS   = 64;
  localparam int END_MARK   = 32'hff;
  localparam int CLK_PERIOD = 10;

  logic                                              clk;
  logic                                              rst_n;
  ic_types_pkg::arb_policy_e                         arb_policy;
  logic [ic_cfg_pkg::N_CORE-1:0]                     core_req;
  logic [ic_cfg_pkg::N_CORE-1:0]                     core_we;
  logic [ic_cfg_pkg::N_CORE-1:0][ic_cfg_pkg::AW-1:0]  core_add;
  logic [ic_cfg_pkg::N_CORE-1:0][ic_cfg_pkg::DW-1:0]  core_wdata;
  logic [ic_cfg_pkg::N_CORE-1:0][ic_cfg_pkg::BEW-1:0] core_be;
  logic [ic_cfg_pkg::N_CORE-1:0]                     core_gnt;
  logic [ic_cfg_pkg::N_CORE-1:0]                     core_r_valid;
  logic [ic_cfg_pkg::N_CORE-1:0][ic_cfg_pkg::DW-1:0]  core_r_rdata;

  logic [31:0] pat_mem [MAX_ROWS*N_COL];
  int          n_rows;

  tb_clk_gen i_clk_gen (
    .clk_o  ( clk   ),
    .rst_no ( rst_n )
  );

  log_interconnect_top DUT (
    .clk_i          ( clk          ),
    .rst_ni         ( rst_n        ),
    .arb_policy_i   ( arb_policy   ),
    .core_req_i     ( core_req     ),
    .core_we_i      ( core_we      ),
    .core_add_i     ( core_add     ),
    .core_wdata_i   ( core_wdata   ),
    .core_be_i      ( core_be      ),
    .core_gnt_o     ( core_gnt     ),
    .core_r_valid_o ( core_r_valid ),
    .core_r_rdata_o ( core_r_rdata )
  );

  function automatic logic [31:0] pat_field(input int row, input int col);
    return pat_mem[row*N_COL + col];
  endfunction

  function automatic string test_name(input int num);
    case (num)
      1:       return "write_read";
      2:       return "byte_enable";
      3:       return "parallel_banks";
      4:       return "fixed_prio";
      5:       return "round_robin";
      6:       return "test_and_set";
      default: return "unknown";
    endcase
  endfunction

  task automatic abort_run();
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_gnt(input string name, input logic [ic_cfg_pkg::N_CORE-1:0] exp_gnt,
                           input logic [ic_cfg_pkg::N_CORE-1:0] act_gnt);
    if (act_gnt !== exp_gnt) begin
      $display("ERR %s gnt: expected %b, actual %b", name, exp_gnt, act_gnt);
      abort_run();
    end
  endtask

  task automatic check_rdata(input string name, input logic [ic_cfg_pkg::DW-1:0] exp_data,
                             input logic [ic_cfg_pkg::DW-1:0] act_data);
    if (act_data !== exp_data) begin
      $display("ERR %s rdata: expected %h, actual %h", name, exp_data, act_data);
      abort_run();
    end
  endtask

  task automatic apply_row(input int row);
    logic [31:0]                               field;
    logic [ic_cfg_pkg::N_CORE-1:0]             req;
    logic [ic_cfg_pkg::N_CORE*ic_cfg_pkg::BEW-1:0] be_all;

    field = pat_field(row, COL_REQ);
    req   = field[ic_cfg_pkg::N_CORE-1:0];
    field = pat_field(row, COL_BE);
    be_all = field[ic_cfg_pkg::N_CORE*ic_cfg_pkg::BEW-1:0];
    core_req <= req;
    field = pat_field(row, COL_WE);
    core_we <= field[ic_cfg_pkg::N_CORE-1:0];
    field = pat_field(row, COL_POL);
    arb_policy <= ic_types_pkg::arb_policy_e'(field[0]);
    for (int c = 0; c < ic_cfg_pkg::N_CORE; c++) begin
      field = pat_field(row, COL_ADD + c);
      core_add[c] <= field[ic_cfg_pkg::AW-1:0];
      core_be[c]  <= be_all[c*ic_cfg_pkg::BEW +: ic_cfg_pkg::BEW];
      if (req[c]) begin
        core_wdata[c] <= pat_field(row, COL_WDATA + c);
      end else begin
        core_wdata[c] <= $urandom;  // idle lane never reaches a bank
      end
    end
  endtask

  task automatic drive_idle();
    core_req <= '0;
    core_we  <= '0;
  endtask

  // responses of the row accepted on the last edge
  task automatic check_responses(input int row, input logic [ic_cfg_pkg::N_CORE-1:0] granted);
    logic [31:0]                   field;
    logic [ic_cfg_pkg::N_CORE-1:0] mask;
    string                         name;

    field = pat_field(row, COL_MASK);
    mask  = field[ic_cfg_pkg::N_CORE-1:0];
    for (int c = 0; c < ic_cfg_pkg::N_CORE; c++) begin
      name = $sformatf("%s row %0d core %0d", test_name(pat_field(row, COL_TEST)), row, c);
      if (granted[c] && core_r_valid[c] !== 1'b1) begin
        $display("core %0d got no r_valid one cycle after its grant in row %0d", c, row);
        abort_run();
      end else if (!granted[c] && core_r_valid[c] !== 1'b0) begin
        $display("core %0d got an r_valid without a grant one cycle earlier", c);
        abort_run();
      end else if (granted[c] && mask[c]) begin
        check_rdata(name, pat_field(row, COL_RDATA + c), core_r_rdata[c]);
      end
    end
  endtask

  task automatic run_watchdog(input int rows);
    #((rows + 10) * CLK_PERIOD);
    $display("watchdog expired after %0d time units and the run did not finish",
             (rows + 10) * CLK_PERIOD);
    abort_run();
  endtask

  initial begin : main
    logic [ic_cfg_pkg::N_CORE-1:0] prev_gnt;
    logic [31:0]                   field;
    int                            prev_row;

    void'($urandom(32'hb151));
    arb_policy = ic_types_pkg::ARB_ROUND_ROBIN;
    core_req   = '0;
    core_we    = '0;
    core_add   = '0;
    core_wdata = '0;
    core_be    = '0;
    prev_gnt   = '0;
    prev_row   = 0;

    $readmemh("tb_patterns.mem", pat_mem);
    n_rows = 0;
    while (n_rows < MAX_ROWS && !$isunknown(pat_field(n_rows, COL_TEST)) &&
           pat_field(n_rows, COL_TEST) != END_MARK) begin
      n_rows++;
    end
    if (n_rows == 0) begin
      $display("no pattern rows found in tb_patterns.mem");
      abort_run();
    end

    fork
      run_watchdog(n_rows);
    join_none

    wait (rst_n === 1'b1);
    for (int r = 0; r < n_rows; r++) begin
      @(posedge clk);
      apply_row(r);
      @(negedge clk);  // gnt settled from this row's inputs
      field = pat_field(r, COL_GNT);
      check_gnt($sformatf("%s row %0d", test_name(pat_field(r, COL_TEST)), r),
                field[ic_cfg_pkg::N_CORE-1:0], core_gnt);
      check_responses(prev_row, prev_gnt);
      prev_gnt = field[ic_cfg_pkg::N_CORE-1:0];
      prev_row = r;
    end

    // one idle cycle to collect the last responses
    @(posedge clk);
    drive_idle();
    @(negedge clk);
    check_gnt("drain", '0, core_gnt);
    check_responses(prev_row, prev_gnt);

    $display("RESULT: PASS");
    $finish;
  end

endmodule

// ==== tb_patterns.mem ====
// test req we pol be add0 add1 add2 add3 wd0 wd1 wd2 wd3 gnt mask rd0 rd1 rd2 rd3
// req, we, gnt and mask have one bit per core, be holds core3..core0 nibbles
// pol 0 is round robin, 1 is fixed priority, rdata belongs to the access granted in that row
1 1 1 0 000f 0010 0 0 0 a0a0a001 0 0 0 1 0 0 0 0 0
1 3 2 0 00f0 0010 0014 0 0 0 b1b1b102 0 0 3 1 a0a0a001 0 0 0
1 6 4 0 0f00 0 0014 0018 0 0 0 c2c2c203 0 6 2 0 b1b1b102 0 0
1 c 8 0 f000 0 0 0018 001c 0 0 0 d3d3d304 c 4 0 0 c2c2c203 0
1 8 0 0 0 0 0 0 001c 0 0 0 0 8 8 0 0 0 d3d3d304
2 6 6 0 0ff0 0 0024 0028 0 0 11223344 55667788 0 6 0 0 0 0 0
2 6 6 0 0850 0 0024 0028 0 0 aabbccdd 99000000 0 6 0 0 0 0 0
2 6 0 0 0 0 0024 0028 0 0 0 0 0 6 6 0 11bb33dd 99667788 0
3 f f 0 ffff 003c 0038 0034 0030 0c0c0c00 1c1c1c01 2c2c2c02 3c3c3c03 f 0 0 0 0 0
3 f 0 0 0 0030 0034 0038 003c 0 0 0 0 f f 3c3c3c03 2c2c2c02 1c1c1c01 0c0c0c00
4 7 7 1 0fff 0040 0050 0060 0 40404040 50505050 60606060 0 1 0 0 0 0 0
4 6 6 1 0ff0 0 0050 0060 0 0 50505050 60606060 0 2 0 0 0 0 0
4 4 4 1 0f00 0 0 0060 0 0 0 60606060 0 4 0 0 0 0 0
4 f 0 1 0 0060 0050 0040 0030 0 0 0 0 1 1 60606060 0 0 0
4 e 0 1 0 0 0050 0040 0030 0 0 0 0 2 2 0 50505050 0 0
4 c 0 1 0 0 0 0040 0030 0 0 0 0 4 4 0 0 40404040 0
4 8 0 1 0 0 0 0 0030 0 0 0 0 8 8 0 0 0 3c3c3c03
5 f 0 0 0 0040 0050 0060 0030 0 0 0 0 1 1 40404040 0 0 0
5 f 0 0 0 0040 0050 0060 0030 0 0 0 0 2 2 0 50505050 0 0
5 d 0 0 0 0040 0 0060 0030 0 0 0 0 4 4 0 0 60606060 0
5 9 0 0 0 0040 0 0 0030 0 0 0 0 8 8 0 0 0 3c3c3c03
5 1 0 0 0 0040 0 0 0 0 0 0 0 1 1 40404040 0 0 0
5 5 0 0 0 0040 0 0060 0 0 0 0 0 4 4 0 0 60606060 0
5 1 0 0 0 0040 0 0 0 0 0 0 0 1 1 40404040 0 0 0
6 6 0 0 0 0 1014 1028 0 0 0 0 0 6 6 0 b1b1b102 99667788 0
6 6 0 0 0 0 0014 0028 0 0 0 0 0 6 6 0 ffffffff ffffffff 0
6 8 8 0 f000 0 0 0 1028 0 0 0 12345678 8 8 0 0 0 ffffffff
6 8 0 0 0 0 0 0 0028 0 0 0 0 8 8 0 0 0 ffffffff
// end marker
ff

// ==== sources.f ====
ic_cfg_pkg.sv
ic_types_pkg.sv
tcdm_bank_intf.sv
ic_req_xbar.sv
ic_bank_arbiter.sv
tcdm_bank.sv
ic_resp_router.sv
log_interconnect_top.sv
tb_clk_gen.sv
tb_log_interconnect.sv

// ==== Bender.yml ====
package:
  name: log_interconnect

sources:
  - ic_cfg_pkg.sv
  - ic_types_pkg.sv
  - tcdm_bank_intf.sv
  - ic_req_xbar.sv
  - ic_bank_arbiter.sv
  - tcdm_bank.sv
  - ic_resp_router.sv
  - log_interconnect_top.sv
  - target: simulation
    files:
      - tb_clk_gen.sv
      - tb_log_interconnect.sv
